/* Bender.yml */
package:
  name: mpr121_controller

sources:
  - files:
      - hdl/mpr121_pkg.sv
      - hdl/i2c_op_if.sv
      - hdl/mpr121_sequencer.sv
      - hdl/i2c_op_fifo.sv
      - hdl/i2c_bit_engine.sv
      - hdl/mpr121_controller.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/mpr121_target_model.sv
      - verification/tb_mpr121_controller.sv

/* files.f */
hdl/mpr121_pkg.sv
hdl/i2c_op_if.sv
hdl/mpr121_sequencer.sv
hdl/i2c_op_fifo.sv
hdl/i2c_bit_engine.sv
hdl/mpr121_controller.sv
verification/tb_clock_gen.sv
verification/mpr121_target_model.sv
verification/tb_mpr121_controller.sv

/* hdl/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine (
	input  logic       i_CLK,
	input  logic       i_RSTN,
	i2c_op_if.pop      op_in,
	input  logic       i_scl,
	input  logic       i_sda,
	output logic       o_scl_drive_low,
	output logic       o_sda_drive_low,
	output logic       o_op_done,
	output logic       o_nack,
	output logic [7:0] o_rd_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START, // also repeated start
		ST_BITS,  // 8 data bits + ack slot
		ST_STOP
	} state_e;

	state_e      state;
	logic [1:0]  phase;     // quarter of the current scl period
	logic [15:0] q_cnt;
	logic        q_tick;
	logic        hold;
	logic [3:0]  bit_cnt;   // 0..7 data, 8 ack
	logic [7:0]  shreg;
	logic        is_read;
	logic [1:0]  scl_sync;
	logic [1:0]  sda_sync;
	logic        scl_s;
	logic        sda_s;

	assign scl_s = scl_sync[1];
	assign sda_s = sda_sync[1];

	assign op_in.ready = (state == ST_IDLE); // one op at a time
	assign o_rd_data   = shreg;

	// pads are asynchronous to i_CLK
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			scl_sync <= 2'b11;
			sda_sync <= 2'b11;
		end
		else
		begin
			scl_sync <= {scl_sync[0], i_scl};
			sda_sync <= {sda_sync[0], i_sda};
		end
	end

	// ==========================================================================
	// quarter period timer
	// ==========================================================================

	// high phase starts counting only once scl is really high (stretching)
	assign hold   = (phase == 2'd1) && !scl_s;
	assign q_tick = (q_cnt == mpr121_pkg::PRESCALE - 16'd1);

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
			q_cnt <= 16'd0;
		else if ((state == ST_IDLE) || q_tick || hold)
			q_cnt <= 16'd0;
		else
			q_cnt <= q_cnt + 16'd1;
	end

	// ==========================================================================
	// bus sequencing
	// ==========================================================================

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			state           <= ST_IDLE;
			phase           <= 2'd0;
			bit_cnt         <= 4'd0;
			shreg           <= 8'h00;
			is_read         <= 1'b0;
			o_scl_drive_low <= 1'b0; // both lines released
			o_sda_drive_low <= 1'b0;
			o_op_done       <= 1'b0;
			o_nack          <= 1'b0;
		end
		else
		begin
			o_op_done <= 1'b0;
			if (state == ST_IDLE)
			begin
				if (op_in.valid)
				begin
					phase   <= 2'd0;
					bit_cnt <= 4'd0;
					shreg   <= op_in.op.data;
					is_read <= (op_in.op.kind == mpr121_pkg::OP_READ);
					o_nack  <= 1'b0;
					case (op_in.op.kind)
						mpr121_pkg::OP_START:
						begin
							o_sda_drive_low <= 1'b0; // sda up, scl left as is
							state           <= ST_START;
						end
						mpr121_pkg::OP_STOP:
						begin
							o_sda_drive_low <= 1'b1; // sda low under scl low
							state           <= ST_STOP;
						end
						default:
						begin
							// first bit, msb; a read keeps sda released
							o_sda_drive_low <= (op_in.op.kind == mpr121_pkg::OP_WRITE) &&
								!op_in.op.data[7];
							state           <= ST_BITS;
						end
					endcase
				end
			end
			else if (q_tick)
			begin
				phase <= phase + 2'd1;
				case (phase)
					2'd0: o_scl_drive_low <= 1'b0; // scl up, held by the hold logic
					2'd1:
					begin
						if (state == ST_START)
							o_sda_drive_low <= 1'b1; // sda falls while scl high
						else if (state == ST_STOP)
							o_sda_drive_low <= 1'b0; // sda rises while scl high
						else if (bit_cnt != 4'd8)
							shreg <= {shreg[6:0], sda_s}; // mid-high sample
						else if (!is_read)
							o_nack <= sda_s; // target ack slot
					end
					2'd2:
					begin
						if (state != ST_STOP)
							o_scl_drive_low <= 1'b1;
					end
					default:
					begin
						if ((state == ST_BITS) && (bit_cnt != 4'd8))
						begin
							bit_cnt         <= bit_cnt + 4'd1;
							// next data bit, released for ack or nack slot
							o_sda_drive_low <= !is_read && !shreg[7] && (bit_cnt != 4'd7);
						end
						else
						begin
							o_op_done <= 1'b1;
							state     <= ST_IDLE;
						end
					end
				endcase
			end
		end
	end

endmodule

/* hdl/i2c_op_fifo.sv */
`timescale 1ns/1ps

module i2c_op_fifo (
	input  logic   i_CLK,
	input  logic   i_RSTN,
	i2c_op_if.pop  in_op,  // from sequencer
	i2c_op_if.push out_op  // to bit engine
);

	mpr121_pkg::i2c_op_t mem [mpr121_pkg::FIFO_DEPTH];

	logic [$clog2(mpr121_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(mpr121_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(mpr121_pkg::FIFO_DEPTH+1)-1:0] count; // 0 .. FIFO_DEPTH
	logic                                        do_push;
	logic                                        do_pop;

	assign in_op.ready  = (count != mpr121_pkg::FIFO_DEPTH);
	assign out_op.valid = (count != 0);
	assign out_op.op    = mem[rd_ptr]; // head entry

	assign do_push = in_op.valid && in_op.ready;
	assign do_pop  = out_op.valid && out_op.ready;

	// storage
	always_ff @(posedge i_CLK)
	begin
		if (do_push)
			mem[wr_ptr] <= in_op.op;
	end

	// pointers and fill level
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == mpr121_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == mpr121_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or none
			endcase
		end
	end

endmodule

/* hdl/i2c_op_if.sv */
`timescale 1ns/1ps

// one bus operation with a valid/ready handshake
interface i2c_op_if (
	input logic i_CLK
);
	mpr121_pkg::i2c_op_t op;
	logic                valid; // held with op stable until accepted
	logic                ready;

	// producer side
	modport push (
		input  i_CLK,
		output op,
		output valid,
		input  ready
	);

	// consumer side
	modport pop (
		input  i_CLK,
		input  op,
		input  valid,
		output ready
	);

endinterface

/* hdl/mpr121_controller.sv */
`timescale 1ns/1ps

module mpr121_controller (
	input  logic       i_CLK,
	input  logic       i_RSTN,
	input  logic [7:0] i_reg_addr,
	input  logic [7:0] i_data_in,
	input  logic       i_write_en,
	input  logic       i_read_en,
	output logic [7:0] o_data_out,
	output logic       o_busy,
	output logic       o_fail,
	inout  wire        io_scl,
	inout  wire        io_sda
);

	logic       scl_drive_low;
	logic       sda_drive_low;
	logic       op_done;
	logic       nack;
	logic [7:0] rd_data;

	i2c_op_if seq_if (.i_CLK(i_CLK)); // sequencer -> queue
	i2c_op_if eng_if (.i_CLK(i_CLK)); // queue -> engine

	// open drain, pull-ups sit outside
	assign io_scl = scl_drive_low ? 1'b0 : 1'bz;
	assign io_sda = sda_drive_low ? 1'b0 : 1'bz;

	mpr121_sequencer sequencer_i (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_reg_addr (i_reg_addr),
		.i_data_in  (i_data_in),
		.i_write_en (i_write_en),
		.i_read_en  (i_read_en),
		.o_data_out (o_data_out),
		.o_busy     (o_busy),
		.o_fail     (o_fail),
		.op_out     (seq_if.push),
		.i_op_done  (op_done),
		.i_nack     (nack),
		.i_rd_data  (rd_data)
	);

	i2c_op_fifo op_fifo_i (
		.i_CLK  (i_CLK),
		.i_RSTN (i_RSTN),
		.in_op  (seq_if.pop),
		.out_op (eng_if.push)
	);

	i2c_bit_engine bit_engine_i (
		.i_CLK           (i_CLK),
		.i_RSTN          (i_RSTN),
		.op_in           (eng_if.pop),
		.i_scl           (io_scl),
		.i_sda           (io_sda),
		.o_scl_drive_low (scl_drive_low),
		.o_sda_drive_low (sda_drive_low),
		.o_op_done       (op_done),
		.o_nack          (nack),
		.o_rd_data       (rd_data)
	);

endmodule

/* hdl/mpr121_pkg.sv */
package mpr121_pkg;

	// ==========================================================================
	// bus constants
	// ==========================================================================

	// ADDR pin tied to 3Vo
	localparam logic [6:0] MPR121_ADDR = 7'h5B;

	// clock cycles per quarter scl period, 125 MHz / (4 * 100 kHz)
	localparam logic [15:0] PRESCALE = 16'd312;

	// bus idle time after the stop, one full scl period
	localparam logic [15:0] SETTLE_CYCLES = PRESCALE * 16'd4;

	// operations in flight between sequencer and engine
	localparam int FIFO_DEPTH = 4;

	// ==========================================================================
	// operation word
	// ==========================================================================

	typedef enum logic [1:0] {
		OP_START = 2'd0, // start or repeated start
		OP_WRITE = 2'd1, // 8 bits out, ack sampled from target
		OP_READ  = 2'd2, // 8 bits in, answered with nack
		OP_STOP  = 2'd3
	} i2c_op_e;

	typedef struct packed {
		i2c_op_e    kind;
		logic [7:0] data; // byte to send, only OP_WRITE looks at it
	} i2c_op_t;

endpackage

/* hdl/mpr121_sequencer.sv */
`timescale 1ns/1ps

module mpr121_sequencer (
	input  logic       i_CLK,
	input  logic       i_RSTN,
	input  logic [7:0] i_reg_addr,
	input  logic [7:0] i_data_in,
	input  logic       i_write_en,
	input  logic       i_read_en,
	output logic [7:0] o_data_out,
	output logic       o_busy,
	output logic       o_fail,
	i2c_op_if.push     op_out,
	input  logic       i_op_done,
	input  logic       i_nack,
	input  logic [7:0] i_rd_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,    // pushing ops and counting them back
		ST_SETTLE, // bus idle wait after the stop
		ST_HOLD    // wait for host to drop its enables
	} state_e;

	state_e              state;
	logic                is_read;
	logic [2:0]          push_idx;   // next op in the list
	logic [2:0]          done_cnt;   // ops finished by the engine
	logic [2:0]          n_ops;
	logic [15:0]         settle_cnt;
	logic                fail_acc;   // sticky nack during the transfer
	logic [7:0]          reg_addr_q;
	logic [7:0]          data_q;
	logic [7:0]          addr_byte;
	mpr121_pkg::i2c_op_t next_op;

	// write: S, addr+W, reg, data, P
	// read:  S, addr+W, reg, Sr, addr+R, rd, P
	assign n_ops = is_read ? 3'd7 : 3'd5;

	// R/W bit set only for the addr byte after the repeated start
	assign addr_byte = {mpr121_pkg::MPR121_ADDR, is_read && (push_idx == 3'd4)};

	// ==========================================================================
	// op list
	// ==========================================================================

	always_comb
	begin
		next_op.kind = mpr121_pkg::OP_STOP;
		next_op.data = 8'h00;
		case (push_idx)
			3'd0: next_op.kind = mpr121_pkg::OP_START;
			3'd1:
			begin
				next_op.kind = mpr121_pkg::OP_WRITE;
				next_op.data = addr_byte;
			end
			3'd2:
			begin
				next_op.kind = mpr121_pkg::OP_WRITE;
				next_op.data = reg_addr_q; // register pointer
			end
			3'd3:
			begin
				if (is_read)
				begin
					next_op.kind = mpr121_pkg::OP_START; // repeated start
				end
				else
				begin
					next_op.kind = mpr121_pkg::OP_WRITE;
					next_op.data = data_q;
				end
			end
			3'd4:
			begin
				if (is_read)
				begin
					next_op.kind = mpr121_pkg::OP_WRITE;
					next_op.data = addr_byte;
				end
			end
			3'd5: next_op.kind = mpr121_pkg::OP_READ;
			default: next_op.kind = mpr121_pkg::OP_STOP;
		endcase
	end

	assign op_out.op    = next_op;
	assign op_out.valid = (state == ST_RUN) && (push_idx != n_ops);

	// request capture, taken on the accepting edge
	always_ff @(posedge i_CLK)
	begin
		if (state == ST_IDLE)
		begin
			reg_addr_q <= i_reg_addr;
			data_q     <= i_data_in;
		end
	end

	// ==========================================================================
	// control
	// ==========================================================================

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			state      <= ST_IDLE;
			is_read    <= 1'b0;
			push_idx   <= 3'd0;
			done_cnt   <= 3'd0;
			settle_cnt <= 16'd0;
			fail_acc   <= 1'b0;
			o_busy     <= 1'b0;
			o_fail     <= 1'b0;
			o_data_out <= 8'h00;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (i_write_en || i_read_en)
					begin
						is_read  <= !i_write_en; // write wins
						push_idx <= 3'd0;
						done_cnt <= 3'd0;
						fail_acc <= 1'b0;
						o_fail   <= 1'b0;
						o_busy   <= 1'b1;
						state    <= ST_RUN;
					end
				end
				ST_RUN:
				begin
					if (op_out.valid && op_out.ready)
						push_idx <= push_idx + 3'd1;
					if (i_op_done)
					begin
						done_cnt <= done_cnt + 3'd1;
						fail_acc <= fail_acc | i_nack; // no abort, stop still goes out
						if (is_read && (done_cnt == 3'd5)) // the OP_READ slot
							o_data_out <= i_rd_data;
						if (done_cnt == n_ops - 3'd1)
						begin
							settle_cnt <= 16'd0;
							state      <= ST_SETTLE;
						end
					end
				end
				ST_SETTLE:
				begin
					if (settle_cnt == mpr121_pkg::SETTLE_CYCLES - 16'd1)
					begin
						o_busy <= 1'b0;
						o_fail <= fail_acc;
						state  <= ST_HOLD;
					end
					else
					begin
						settle_cnt <= settle_cnt + 16'd1;
					end
				end
				ST_HOLD:
				begin
					if (!i_write_en && !i_read_en)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* verification/mpr121_target_model.sv */
`timescale 1ns/1ps

// behavioral i2c target, register pointer with auto increment
module mpr121_target_model #(
	parameter int STRETCH_NS = 8000 // scl held low after each falling edge
) (
	inout  wire         io_scl,
	inout  wire         io_sda,
	input  logic [6:0]  i_addr,
	input  logic        i_stretch,
	output logic [15:0] o_xfer_cnt   // stop conditions seen
);

	typedef enum logic [2:0] {
		T_IDLE,
		T_ADDR,
		T_REG,
		T_WDATA,
		T_RDATA,
		T_IGNORE // not addressed, or read byte done
	} tstate_e;

	logic [7:0] regs [256]; // register file, peeked by the testbench
	tstate_e    state;
	logic [7:0] shift;
	logic [7:0] rbyte;
	logic [7:0] ptr;
	logic [3:0] cnt;        // scl rising edges in this byte, 9 with ack
	logic       sda_low;
	logic       scl_low;

	assign io_sda = sda_low ? 1'b0 : 1'bz;
	assign io_scl = scl_low ? 1'b0 : 1'bz;

	initial
	begin
		state      = T_IDLE;
		cnt        = 4'd0;
		ptr        = 8'h00;
		sda_low    = 1'b0;
		scl_low    = 1'b0;
		o_xfer_cnt = 16'd0;
		for (int i = 0; i < 256; i++)
			regs[i] = 8'(i) ^ 8'h5c; // fill tied to the address
	end

	// ==========================================================================
	// bus conditions
	// ==========================================================================

	// start or repeated start
	always @(negedge io_sda)
	begin
		if (io_scl === 1'b1)
		begin
			state   = T_ADDR;
			cnt     = 4'd0;
			sda_low = 1'b0;
		end
	end

	// stop
	always @(posedge io_sda)
	begin
		if ((io_scl === 1'b1) && (state != T_IDLE))
		begin
			state      = T_IDLE;
			o_xfer_cnt = o_xfer_cnt + 16'd1;
		end
	end

	always @(posedge io_scl)
	begin
		if ((state != T_IDLE) && (state != T_IGNORE))
		begin
			if (cnt < 4'd8)
				shift = {shift[6:0], io_sda}; // msb first
			cnt = cnt + 4'd1;
		end
	end

	// ==========================================================================
	// sda changes only while scl is low
	// ==========================================================================

	always @(negedge io_scl)
	begin
		if (cnt == 4'd8)
		begin
			case (state)
				T_ADDR:
				begin
					if (shift[7:1] == i_addr)
						sda_low = 1'b1;
					else
						state = T_IGNORE; // nack, stay off the bus
				end
				T_REG:
				begin
					ptr     = shift;
					sda_low = 1'b1;
				end
				T_WDATA:
				begin
					regs[ptr] = shift;
					ptr       = ptr + 8'd1;
					sda_low   = 1'b1;
				end
				default: sda_low = 1'b0; // read, host answers
			endcase
		end
		else if (cnt == 4'd9)
		begin
			sda_low = 1'b0;
			cnt     = 4'd0;
			case (state)
				T_ADDR:  state = shift[0] ? T_RDATA : T_REG;
				T_REG:   state = T_WDATA;
				T_RDATA: state = T_IGNORE; // one byte only
				default: state = state;
			endcase
			if (state == T_RDATA)
			begin
				rbyte   = regs[ptr];
				ptr     = ptr + 8'd1;
				sda_low = !rbyte[7];
			end
		end
		else if ((state == T_RDATA) && (cnt != 4'd0))
		begin
			sda_low = !rbyte[7 - cnt]; // bits 6..0
		end
		if (i_stretch && (state != T_IDLE))
		begin
			scl_low = 1'b1;
			#(STRETCH_NS);
			scl_low = 1'b0;
		end
	end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

// 125 MHz clock plus active low reset for three cycles
module tb_clock_gen (
	output logic o_clk,
	output logic o_rstn
);

	initial
	begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk; // 8 ns period
	end

	initial
	begin
		o_rstn = 1'b0;
		repeat (3) @(posedge o_clk);
		#1 o_rstn = 1'b1; // released off the edge
	end

endmodule

/* verification/tb_mpr121_controller.sv */
`timescale 1ns/1ps

module tb_mpr121_controller;

	localparam logic [31:0] SEED         = 32'h75a5_ee66;
	localparam int          RISE_TIMEOUT = 16;      // cycles until o_busy goes high
	localparam int          DONE_TIMEOUT = 200_000; // covers a stretched read
	localparam int          HOLD_CYCLES  = 4000;    // window with the enable kept high
	localparam logic [6:0]  WRONG_ADDR   = 7'h5A;

	logic        clk;
	logic        rstn;
	logic [7:0]  reg_addr;
	logic [7:0]  data_in;
	logic        write_en;
	logic        read_en;
	logic [7:0]  data_out;
	logic        busy;
	logic        fail;
	wire         scl;
	wire         sda;
	logic [6:0]  tgt_addr;
	logic        stretch;
	logic [15:0] xfer_cnt;

	tb_clock_gen clock_gen_i (
		.o_clk  (clk),
		.o_rstn (rstn)
	);

	mpr121_controller mpr121_controller_i (
		.i_CLK      (clk),
		.i_RSTN     (rstn),
		.i_reg_addr (reg_addr),
		.i_data_in  (data_in),
		.i_write_en (write_en),
		.i_read_en  (read_en),
		.o_data_out (data_out),
		.o_busy     (busy),
		.o_fail     (fail),
		.io_scl     (scl),
		.io_sda     (sda)
	);

	pullup (scl);
	pullup (sda);

	mpr121_target_model target_i (
		.io_scl     (scl),
		.io_sda     (sda),
		.i_addr     (tgt_addr),
		.i_stretch  (stretch),
		.o_xfer_cnt (xfer_cnt)
	);

	// ==========================================================================
	// helpers
	// ==========================================================================

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rstn !== 1'b1)
		begin
			@(negedge clk);
			n++;
			if (n > 16)
			begin
				$display("Reset was never released");
				abort_run();
			end
		end
	endtask

	// sampled on the falling edge, away from the dut's updates
	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (busy !== level)
		begin
			@(negedge clk);
			n++;
			if (n > limit)
			begin
				$display("Timeout: %s", what);
				abort_run();
			end
		end
	endtask

	task automatic start_cmd(input logic is_write, input logic [7:0] addr,
		input logic [7:0] data);
		@(posedge clk);
		#1;
		reg_addr = addr;
		data_in  = data;
		write_en = is_write;
		read_en  = !is_write;
		wait_busy(1'b1, RISE_TIMEOUT, "o_busy did not rise after the enable");
		wait_busy(1'b0, DONE_TIMEOUT, "o_busy did not fall, bus transfer stuck");
	endtask

	task automatic drop_enables();
		@(posedge clk);
		#1;
		write_en = 1'b0;
		read_en  = 1'b0;
	endtask

	// ==========================================================================
	// tests
	// ==========================================================================

	task automatic test_reset_state();
		@(negedge clk);
		check_value("o_busy", busy, 0);
		check_value("o_fail", fail, 0);
		check_value("o_data_out", data_out, 0);
		check_value("io_scl", scl, 1);
		check_value("io_sda", sda, 1);
	endtask

	task automatic test_write(input logic [7:0] addr, input logic [7:0] data);
		start_cmd(1'b1, addr, data);
		drop_enables();
		check_value("target reg", target_i.regs[addr], data);
		check_value("o_fail", fail, 0);
	endtask

	task automatic test_read(input logic [7:0] addr, input logic [7:0] exp);
		start_cmd(1'b0, addr, 8'h00);
		drop_enables();
		check_value("o_data_out", data_out, exp);
		check_value("o_fail", fail, 0);
	endtask

	task automatic test_random_pairs(input int n);
		logic [7:0] a;
		logic [7:0] d;
		for (int i = 0; i < n; i++)
		begin
			a = 8'($urandom);
			d = 8'($urandom);
			test_write(a, d);
			test_read(a, d);
		end
	endtask

	// nack on the address byte, bus must still end released
	task automatic check_failed_end();
		@(negedge clk);
		check_value("o_fail", fail, 1);
		check_value("o_busy", busy, 0);
		check_value("io_scl", scl, 1);
		check_value("io_sda", sda, 1);
	endtask

	task automatic test_wrong_addr();
		logic [7:0] orig_val;
		orig_val = target_i.regs[8'h2a];
		tgt_addr = WRONG_ADDR;
		start_cmd(1'b1, 8'h2a, ~orig_val);
		drop_enables();
		check_failed_end();
		check_value("target reg", target_i.regs[8'h2a], orig_val);
		start_cmd(1'b0, 8'h2a, 8'h00);
		drop_enables();
		check_failed_end();
		tgt_addr = mpr121_pkg::MPR121_ADDR;
		test_write(8'h2a, ~orig_val); // also checks o_fail back at 0
	endtask

	task automatic test_enable_hold();
		logic [15:0] cnt0;
		logic [7:0]  d;
		cnt0 = xfer_cnt;
		d    = 8'($urandom);
		start_cmd(1'b1, 8'h41, d);
		repeat (HOLD_CYCLES) // enable still high, nothing may restart
		begin
			@(negedge clk);
			check_value("o_busy", busy, 0);
		end
		check_value("transfer count", xfer_cnt, cnt0 + 16'd1);
		drop_enables();
		test_write(8'h41, ~d);
		check_value("transfer count", xfer_cnt, cnt0 + 16'd2);
	endtask

	initial
	begin
		void'($urandom(SEED));
		reg_addr = 8'h00;
		data_in  = 8'h00;
		write_en = 1'b0;
		read_en  = 1'b0;
		tgt_addr = mpr121_pkg::MPR121_ADDR;
		stretch  = 1'b0;
		wait_reset();
		test_reset_state();
		test_write(8'h5e, 8'($urandom));
		target_i.regs[8'h5d] = 8'hb7; // preload for the first read
		test_read(8'h5d, 8'hb7);
		test_random_pairs(4);
		test_wrong_addr();
		stretch = 1'b1;
		test_random_pairs(2);
		stretch = 1'b0;
		test_enable_hold();
		$display("All tests passed!");
		$finish;
	end

endmodule
